// ==== logic/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [11:0] sys_code_t;
    typedef logic [3:0]  exc_t;

    // bit positions inside exc_t
    localparam int EXC_ILLEGAL = 0;
    localparam int EXC_ECALL   = 1;
    localparam int EXC_EBREAK  = 2;
    localparam int EXC_MRET    = 3;

    typedef enum logic [3:0] {
        CLS_RTYPE, CLS_ITYPE, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JAL,
        CLS_JALR, CLS_LUI, CLS_AUIPC, CLS_SYSTEM, CLS_FENCE, CLS_NONE
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_EQ, ALU_NEQ, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU
    } alu_op_e;

    localparam opcode_t OPC_RTYPE  = 7'b0110011;
    localparam opcode_t OPC_ITYPE  = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;

    // arithmetic and logic ops, shared by R-type and I-type
    localparam funct3_t F3_ADD  = 3'd0;
    localparam funct3_t F3_SLL  = 3'd1;
    localparam funct3_t F3_SLT  = 3'd2;
    localparam funct3_t F3_SLTU = 3'd3;
    localparam funct3_t F3_XOR  = 3'd4;
    localparam funct3_t F3_SRL  = 3'd5;
    localparam funct3_t F3_OR   = 3'd6;
    localparam funct3_t F3_AND  = 3'd7;

    localparam funct3_t F3_BEQ  = 3'd0;
    localparam funct3_t F3_BNE  = 3'd1;
    localparam funct3_t F3_BLT  = 3'd4;
    localparam funct3_t F3_BGE  = 3'd5;
    localparam funct3_t F3_BLTU = 3'd6;
    localparam funct3_t F3_BGEU = 3'd7;

    localparam funct3_t F3_LB   = 3'd0;
    localparam funct3_t F3_LH   = 3'd1;
    localparam funct3_t F3_LW   = 3'd2;
    localparam funct3_t F3_LBU  = 3'd4;
    localparam funct3_t F3_LHU  = 3'd5;

    localparam funct3_t F3_SB   = 3'd0;
    localparam funct3_t F3_SH   = 3'd1;
    localparam funct3_t F3_SW   = 3'd2;

    localparam funct3_t F3_FENCE   = 3'd0;
    localparam funct3_t F3_FENCE_I = 3'd1;
    localparam funct3_t F3_PRIV    = 3'd0;

    localparam funct7_t F7_ZERO = 7'h00;
    localparam funct7_t F7_ALT  = 7'h20;

    localparam sys_code_t SYS_ECALL  = 12'h000;
    localparam sys_code_t SYS_EBREAK = 12'h001;
    localparam sys_code_t SYS_MRET   = 12'h302;

endpackage

`default_nettype wire

// ==== logic/decode_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// decoded fields travelling from the two decoders into the stage register
interface decode_bus_if;
    import rv_decode_pkg::*;

    op_class_e op_class;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    funct3_t   funct3;
    data_t     imm;
    alu_op_e   alu_op;
    exc_t      exc;

    modport fields (
        output op_class, rs1, rs2, rd, funct3, imm
    );

    modport verdict (
        input  op_class, funct3,
        output alu_op, exc
    );

    modport sink (
        input op_class, rs1, rs2, rd, funct3, imm, alu_op, exc
    );

endinterface

`default_nettype wire

// ==== logic/field_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module field_decoder (
    input  rv_decode_pkg::instr_t instr,
    decode_bus_if.fields          bus
);
    import rv_decode_pkg::*;

    opcode_t   opcode;
    op_class_e op_class;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    funct3_t   funct3;
    data_t     imm;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            OPC_RTYPE:  op_class = CLS_RTYPE;
            OPC_ITYPE:  op_class = CLS_ITYPE;
            OPC_LOAD:   op_class = CLS_LOAD;
            OPC_STORE:  op_class = CLS_STORE;
            OPC_BRANCH: op_class = CLS_BRANCH;
            OPC_JAL:    op_class = CLS_JAL;
            OPC_JALR:   op_class = CLS_JALR;
            OPC_LUI:    op_class = CLS_LUI;
            OPC_AUIPC:  op_class = CLS_AUIPC;
            OPC_SYSTEM: op_class = CLS_SYSTEM;
            OPC_FENCE:  op_class = CLS_FENCE;
            default:    op_class = CLS_NONE;
        endcase
    end

    // unused register slots stay at x0 so hazard logic downstream sees no false match
    always_comb begin
        rs1    = '0;
        rs2    = '0;
        rd     = '0;
        funct3 = '0;
        case (op_class)
            CLS_RTYPE: begin
                rs1    = instr[19:15];
                rs2    = instr[24:20];
                rd     = instr[11:7];
                funct3 = instr[14:12];
            end
            CLS_ITYPE, CLS_LOAD, CLS_JALR, CLS_SYSTEM, CLS_FENCE: begin
                rs1    = instr[19:15];
                rd     = instr[11:7];
                funct3 = instr[14:12];
            end
            CLS_STORE, CLS_BRANCH: begin
                rs1    = instr[19:15];
                rs2    = instr[24:20];
                funct3 = instr[14:12];
            end
            CLS_LUI, CLS_AUIPC, CLS_JAL: begin
                rd = instr[11:7];
            end
            default: begin
                rd = '0;
            end
        endcase
    end

    always_comb begin
        case (op_class)
            CLS_ITYPE, CLS_LOAD, CLS_JALR:
                imm = {{20{instr[31]}}, instr[31:20]};
            CLS_STORE:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            CLS_BRANCH:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            CLS_JAL:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            CLS_LUI, CLS_AUIPC:
                imm = {instr[31:12], 12'b0};
            // system code or fence bits, not sign extended
            CLS_SYSTEM, CLS_FENCE:
                imm = {20'b0, instr[31:20]};
            default:
                imm = '0;
        endcase
    end

    assign bus.op_class = op_class;
    assign bus.rs1      = rs1;
    assign bus.rs2      = rs2;
    assign bus.rd       = rd;
    assign bus.funct3   = funct3;
    assign bus.imm      = imm;

endmodule

`default_nettype wire

// ==== logic/instr_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_checker (
    input  rv_decode_pkg::instr_t instr,
    decode_bus_if.verdict         bus
);
    import rv_decode_pkg::*;

    funct7_t   funct7;
    sys_code_t sys_code;
    alu_op_e   alu_op;
    logic      illegal;
    logic      is_priv;
    exc_t      exc;

    assign funct7   = instr[31:25];
    assign sys_code = instr[31:20];

    always_comb begin
        alu_op = ALU_ADD;
        if (bus.op_class == CLS_RTYPE || bus.op_class == CLS_ITYPE) begin
            case (bus.funct3)
                // I-type has no subtract, only R-type looks at funct7 here
                F3_ADD:  alu_op = (bus.op_class == CLS_RTYPE && funct7 == F7_ALT) ?
                                  ALU_SUB : ALU_ADD;
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SRL:  alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end else if (bus.op_class == CLS_BRANCH) begin
            case (bus.funct3)
                F3_BEQ:  alu_op = ALU_EQ;
                F3_BNE:  alu_op = ALU_NEQ;
                F3_BLT:  alu_op = ALU_LT;
                F3_BGE:  alu_op = ALU_GE;
                F3_BLTU: alu_op = ALU_LTU;
                F3_BGEU: alu_op = ALU_GEU;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        illegal = 1'b0;
        case (bus.op_class)
            CLS_NONE:
                illegal = 1'b1;
            CLS_RTYPE:
                // only ADD/SUB and SRL/SRA have an alternate funct7 encoding
                illegal = (funct7 != F7_ZERO) &&
                          !((bus.funct3 == F3_ADD || bus.funct3 == F3_SRL) &&
                            funct7 == F7_ALT);
            CLS_ITYPE: begin
                if (bus.funct3 == F3_SLL) begin
                    illegal = (funct7 != F7_ZERO);
                end else if (bus.funct3 == F3_SRL) begin
                    illegal = !(funct7 == F7_ZERO || funct7 == F7_ALT);
                end
            end
            CLS_LOAD:
                illegal = !(bus.funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
            CLS_STORE:
                illegal = !(bus.funct3 inside {F3_SB, F3_SH, F3_SW});
            CLS_BRANCH:
                illegal = !(bus.funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE,
                                               F3_BLTU, F3_BGEU});
            CLS_FENCE:
                illegal = !(bus.funct3 inside {F3_FENCE, F3_FENCE_I});
            default:
                illegal = 1'b0;
        endcase
    end

    assign is_priv = (bus.op_class == CLS_SYSTEM) && (bus.funct3 == F3_PRIV);

    always_comb begin
        exc              = '0;
        exc[EXC_ILLEGAL] = illegal;
        exc[EXC_ECALL]   = is_priv && (sys_code == SYS_ECALL);
        exc[EXC_EBREAK]  = is_priv && (sys_code == SYS_EBREAK);
        exc[EXC_MRET]    = is_priv && (sys_code == SYS_MRET);
    end

    assign bus.alu_op = alu_op;
    assign bus.exc    = exc;

endmodule

`default_nettype wire

// ==== logic/decode_stage_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage_reg #(
    parameter int PC_WIDTH = 32
) (
    input  logic                     d_clk,
    input  logic                     d_rst,
    input  logic [PC_WIDTH-1:0]      pc,
    input  logic                     in_valid,
    input  logic                     stall_in,
    input  logic                     flush_in,
    decode_bus_if.sink               bus,
    output logic [PC_WIDTH-1:0]      out_pc,
    output rv_decode_pkg::op_class_e out_class,
    output rv_decode_pkg::reg_addr_t out_rs1,
    output rv_decode_pkg::reg_addr_t out_rs2,
    output rv_decode_pkg::reg_addr_t out_rd,
    output rv_decode_pkg::funct3_t   out_funct3,
    output rv_decode_pkg::data_t     out_imm,
    output rv_decode_pkg::alu_op_e   out_alu,
    output rv_decode_pkg::exc_t      out_exc,
    output logic                     out_valid,
    output logic                     stall_out,
    output logic                     flush_out
);
    import rv_decode_pkg::*;

    logic self_stall;
    logic enable;

    // an illegal word holds the upstream for the one cycle it is presented
    assign self_stall = out_valid && out_exc[EXC_ILLEGAL];
    assign stall_out  = stall_in || self_stall;
    assign flush_out  = flush_in || out_exc[EXC_ECALL];

    // stall_out already folds in stall_in
    assign enable = in_valid && !stall_out;

    always_ff @(posedge d_clk or negedge d_rst) begin
        if (!d_rst) begin
            out_valid  <= 1'b0;
            out_exc    <= '0;
            out_pc     <= '0;
            out_class  <= CLS_RTYPE;
            out_rs1    <= '0;
            out_rs2    <= '0;
            out_rd     <= '0;
            out_funct3 <= '0;
            out_imm    <= '0;
            out_alu    <= ALU_ADD;
        end else if (!stall_in) begin
            // a flushed word still loads but leaves as a bubble
            out_valid <= enable && !flush_in;
            if (enable) begin
                out_exc    <= bus.exc;
                out_pc     <= pc;
                out_class  <= bus.op_class;
                out_rs1    <= bus.rs1;
                out_rs2    <= bus.rs2;
                out_rd     <= bus.rd;
                out_funct3 <= bus.funct3;
                out_imm    <= bus.imm;
                out_alu    <= bus.alu_op;
            end else begin
                // bubble or end of a self stall, no trap may linger
                out_exc <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_top #(
    parameter int PC_WIDTH = 32
) (
    input  logic                     d_clk,
    input  logic                     d_rst,
    input  rv_decode_pkg::instr_t    instr,
    input  logic [PC_WIDTH-1:0]      pc,
    input  logic                     in_valid,
    input  logic                     stall_in,
    input  logic                     flush_in,
    output logic [PC_WIDTH-1:0]      out_pc,
    output rv_decode_pkg::op_class_e out_class,
    output rv_decode_pkg::reg_addr_t out_rs1,
    output rv_decode_pkg::reg_addr_t out_rs2,
    output rv_decode_pkg::reg_addr_t out_rd,
    output rv_decode_pkg::funct3_t   out_funct3,
    output rv_decode_pkg::data_t     out_imm,
    output rv_decode_pkg::alu_op_e   out_alu,
    output rv_decode_pkg::exc_t      out_exc,
    output logic                     out_valid,
    output logic                     stall_out,
    output logic                     flush_out
);

    decode_bus_if bus_i ();

    // both decoders see the raw word in the same cycle
    field_decoder fields_i (
        .instr (instr),
        .bus   (bus_i.fields)
    );

    instr_checker checker_i (
        .instr (instr),
        .bus   (bus_i.verdict)
    );

    decode_stage_reg #(
        .PC_WIDTH (PC_WIDTH)
    ) stage_i (
        .d_clk      (d_clk),
        .d_rst      (d_rst),
        .pc         (pc),
        .in_valid   (in_valid),
        .stall_in   (stall_in),
        .flush_in   (flush_in),
        .bus        (bus_i.sink),
        .out_pc     (out_pc),
        .out_class  (out_class),
        .out_rs1    (out_rs1),
        .out_rs2    (out_rs2),
        .out_rd     (out_rd),
        .out_funct3 (out_funct3),
        .out_imm    (out_imm),
        .out_alu    (out_alu),
        .out_exc    (out_exc),
        .out_valid  (out_valid),
        .stall_out  (stall_out),
        .flush_out  (flush_out)
    );

endmodule

`default_nettype wire

// ==== verification/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected contents of the stage register for one accepted word
typedef struct packed {
    op_class_e cls;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    funct3_t   f3;
    data_t     imm;
    alu_op_e   alu;
    exc_t      exc;
} expect_t;

function automatic op_class_e classify(input logic [6:0] opc);
    case (opc)
        OPC_RTYPE:  return CLS_RTYPE;
        OPC_ITYPE:  return CLS_ITYPE;
        OPC_LOAD:   return CLS_LOAD;
        OPC_STORE:  return CLS_STORE;
        OPC_BRANCH: return CLS_BRANCH;
        OPC_JAL:    return CLS_JAL;
        OPC_JALR:   return CLS_JALR;
        OPC_LUI:    return CLS_LUI;
        OPC_AUIPC:  return CLS_AUIPC;
        OPC_SYSTEM: return CLS_SYSTEM;
        OPC_FENCE:  return CLS_FENCE;
        default:    return CLS_NONE;
    endcase
endfunction

function automatic expect_t expected_decode(input instr_t w);
    expect_t e;
    funct3_t f3;
    funct7_t f7;
    logic    rtype;
    f3 = w[14:12];
    f7 = w[31:25];
    e = '0;
    e.cls = classify(w[6:0]);
    e.alu = ALU_ADD;
    rtype = (e.cls == CLS_RTYPE);
    if (e.cls inside {CLS_RTYPE, CLS_ITYPE, CLS_LOAD, CLS_JALR, CLS_SYSTEM, CLS_FENCE,
                      CLS_STORE, CLS_BRANCH})
        e.rs1 = w[19:15];
    if (e.cls inside {CLS_RTYPE, CLS_STORE, CLS_BRANCH})
        e.rs2 = w[24:20];
    if (!(e.cls inside {CLS_STORE, CLS_BRANCH, CLS_NONE}))
        e.rd = w[11:7];
    if (!(e.cls inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_NONE}))
        e.f3 = f3;
    case (e.cls)
        CLS_ITYPE, CLS_LOAD, CLS_JALR: e.imm = {{20{w[31]}}, w[31:20]};
        CLS_STORE:  e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        CLS_BRANCH: e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        CLS_JAL:    e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        CLS_LUI, CLS_AUIPC: e.imm = {w[31:12], 12'h000};
        CLS_SYSTEM, CLS_FENCE: e.imm = {20'h00000, w[31:20]};
        default:    e.imm = '0;
    endcase
    if (rtype || e.cls == CLS_ITYPE) begin
        case (f3)
            3'd0: e.alu = (rtype && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            3'd1: e.alu = ALU_SLL;
            3'd2: e.alu = ALU_SLT;
            3'd3: e.alu = ALU_SLTU;
            3'd4: e.alu = ALU_XOR;
            3'd5: e.alu = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            3'd6: e.alu = ALU_OR;
            default: e.alu = ALU_AND;
        endcase
    end else if (e.cls == CLS_BRANCH) begin
        case (f3)
            3'd0: e.alu = ALU_EQ;
            3'd1: e.alu = ALU_NEQ;
            3'd4: e.alu = ALU_LT;
            3'd5: e.alu = ALU_GE;
            3'd6: e.alu = ALU_LTU;
            3'd7: e.alu = ALU_GEU;
            default: e.alu = ALU_ADD;
        endcase
    end
    case (e.cls)
        CLS_NONE:   e.exc[EXC_ILLEGAL] = 1'b1;
        CLS_RTYPE:  e.exc[EXC_ILLEGAL] = f7 != F7_ZERO &&
                        !((f3 == 3'd0 || f3 == 3'd5) && f7 == F7_ALT);
        CLS_ITYPE:  e.exc[EXC_ILLEGAL] = (f3 == 3'd1 && f7 != F7_ZERO) ||
                        (f3 == 3'd5 && f7 != F7_ZERO && f7 != F7_ALT);
        CLS_LOAD:   e.exc[EXC_ILLEGAL] = (f3 == 3'd3 || f3 > 3'd5);
        CLS_STORE:  e.exc[EXC_ILLEGAL] = (f3 > 3'd2);
        CLS_BRANCH: e.exc[EXC_ILLEGAL] = (f3 == 3'd2 || f3 == 3'd3);
        CLS_FENCE:  e.exc[EXC_ILLEGAL] = (f3 > 3'd1);
        default:    e.exc[EXC_ILLEGAL] = 1'b0;
    endcase
    if (e.cls == CLS_SYSTEM && f3 == 3'd0) begin
        e.exc[EXC_ECALL]  = (w[31:20] == SYS_ECALL);
        e.exc[EXC_EBREAK] = (w[31:20] == SYS_EBREAK);
        e.exc[EXC_MRET]   = (w[31:20] == SYS_MRET);
    end
    return e;
endfunction

`endif

// ==== verification/decode_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_tb;
    import rv_decode_pkg::*;

    `include "decode_model.svh"

    // words per test times a worst case of eight cycles each, plus margin
    localparam int CYCLE_LIMIT = (300 + 100 + 8 + 100 + 100) * 8 + 200;

    logic        d_clk;
    logic        d_rst;
    instr_t      instr;
    logic [31:0] pc;
    logic        in_valid;
    logic        stall_in;
    logic        flush_in;
    logic [31:0] out_pc;
    op_class_e   out_class;
    reg_addr_t   out_rs1;
    reg_addr_t   out_rs2;
    reg_addr_t   out_rd;
    funct3_t     out_funct3;
    data_t       out_imm;
    alu_op_e     out_alu;
    exc_t        out_exc;
    logic        out_valid;
    logic        stall_out;
    logic        flush_out;

    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          cycles = 0;
    logic        checking;
    logic        taken;
    logic        taken_flush;
    logic        held;
    expect_t     exp_q[$];
    logic [31:0] pc_q[$];
    // model of what the stage register holds right now
    expect_t     cur;
    logic [31:0] cur_pc;
    logic        cur_valid;

    opcode_t opc_list[11] = '{OPC_RTYPE, OPC_ITYPE, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                              OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC, OPC_SYSTEM, OPC_FENCE};
    funct3_t load_f3[5]   = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    funct3_t branch_f3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    instr_t  sys_words[8] = '{32'h00000073, 32'h00100073, 32'h30200073, 32'h00000ef3,
                              32'h00002073, 32'h00101073, 32'h30201073, 32'h10500073};

    decode_top #(.PC_WIDTH(32)) dut_i (
        .d_clk      (d_clk),
        .d_rst      (d_rst),
        .instr      (instr),
        .pc         (pc),
        .in_valid   (in_valid),
        .stall_in   (stall_in),
        .flush_in   (flush_in),
        .out_pc     (out_pc),
        .out_class  (out_class),
        .out_rs1    (out_rs1),
        .out_rs2    (out_rs2),
        .out_rd     (out_rd),
        .out_funct3 (out_funct3),
        .out_imm    (out_imm),
        .out_alu    (out_alu),
        .out_exc    (out_exc),
        .out_valid  (out_valid),
        .stall_out  (stall_out),
        .flush_out  (flush_out)
    );

    initial begin
        d_clk = 1'b0;
        forever #50 d_clk = ~d_clk;
    end

    task automatic note_result(input string name, input logic bad, input string got_s,
                               input string exp_s);
        checks++;
        test_checks++;
        if (bad) begin
            errors++;
            test_errors++;
            $display("Fail %s got 0x%s expected 0x%s at %0t", name, got_s, exp_s, $time);
        end
    endtask

    task automatic compare_class(input string name, input op_class_e got, input op_class_e exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_funct3(input string name, input funct3_t got, input funct3_t exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_imm(input string name, input data_t got, input data_t exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_pc(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_alu(input string name, input alu_op_e got, input alu_op_e exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_exc(input string name, input exc_t got, input exc_t exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        note_result(name, got !== exp, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic compare_fields(input expect_t e, input logic [31:0] epc);
        compare_class("out_class", out_class, e.cls);
        compare_reg("out_rs1", out_rs1, e.rs1);
        compare_reg("out_rs2", out_rs2, e.rs2);
        compare_reg("out_rd", out_rd, e.rd);
        compare_funct3("out_funct3", out_funct3, e.f3);
        compare_imm("out_imm", out_imm, e.imm);
        compare_alu("out_alu", out_alu, e.alu);
        compare_exc("out_exc", out_exc, e.exc);
        compare_pc("out_pc", out_pc, epc);
    endtask

    // outputs are settled at the falling edge, so all checks happen there
    task automatic check_cycle();
        if (taken) begin
            cur = exp_q.pop_front();
            cur_pc = pc_q.pop_front();
            cur_valid = !taken_flush;
        end else if (!held) begin
            // a bubble or the end of a self stall clears valid and any trap
            cur_valid = 1'b0;
            cur.exc = '0;
        end
        compare_bit("out_valid", out_valid, cur_valid);
        compare_fields(cur, cur_pc);
        compare_bit("stall_out", stall_out, stall_in | (cur_valid & cur.exc[EXC_ILLEGAL]));
        compare_bit("flush_out", flush_out, flush_in | cur.exc[EXC_ECALL]);
        held = stall_in;
        taken = in_valid && !stall_out;
        taken_flush = flush_in;
        if (taken) begin
            exp_q.push_back(expected_decode(instr));
            pc_q.push_back(pc);
        end
    endtask

    always @(negedge d_clk) begin
        if (checking)
            check_cycle();
    end

    always @(posedge d_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic chance(input int pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic instr_t legal_word();
        instr_t  w;
        int      k;
        funct3_t f3;
        w = $urandom;
        k = $urandom % 11;
        f3 = w[14:12];
        w[6:0] = opc_list[k];
        case (k)
            0: w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? F7_ALT : F7_ZERO;
            1: begin
                if (f3 == 3'd1)
                    w[31:25] = F7_ZERO;
                else if (f3 == 3'd5)
                    w[31:25] = w[30] ? F7_ALT : F7_ZERO;
            end
            2: w[14:12] = load_f3[$urandom % 5];
            3: w[14:12] = 3'($urandom % 3);
            4: w[14:12] = branch_f3[$urandom % 6];
            6: w[14:12] = 3'd0;
            10: w[14:12] = {2'b00, w[12]};
            default: w[14:12] = f3;
        endcase
        return w;
    endfunction

    function automatic instr_t any_word();
        instr_t w;
        w = $urandom;
        if ($urandom % 4 != 0)
            w[6:0] = opc_list[$urandom % 11];
        return w;
    endfunction

    // called right after a rising edge, returns on the edge that accepts the word
    task automatic send_word(input instr_t w, input int stall_pct, input int flush_pct);
        instr <= w;
        pc <= $urandom;
        in_valid <= 1'b1;
        stall_in <= chance(stall_pct);
        flush_in <= chance(flush_pct);
        @(posedge d_clk);
        while (!taken) begin
            stall_in <= chance(stall_pct);
            flush_in <= chance(flush_pct);
            @(posedge d_clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        in_valid <= 1'b0;
        stall_in <= 1'b0;
        flush_in <= 1'b0;
        repeat (n) @(posedge d_clk);
    endtask

    task automatic maybe_gap();
        if ($urandom % 3 == 0)
            idle_cycles(1 + $urandom % 3);
    endtask

    task automatic finish_test(input string name);
        idle_cycles(3);
        $display("test %s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        void'($urandom(32'h6298));
        checks = 0;
        errors = 0;
        test_checks = 0;
        test_errors = 0;
        checking = 1'b0;
        taken = 1'b0;
        taken_flush = 1'b0;
        held = 1'b0;
        cur = '0;
        cur_pc = '0;
        cur_valid = 1'b0;
        d_rst <= 1'b0;
        instr <= '0;
        pc <= '0;
        in_valid <= 1'b0;
        stall_in <= 1'b0;
        flush_in <= 1'b0;
        repeat (5) @(posedge d_clk);
        d_rst <= 1'b1;

        @(negedge d_clk);
        compare_bit("out_valid", out_valid, 1'b0);
        compare_bit("stall_out", stall_out, 1'b0);
        compare_bit("flush_out", flush_out, 1'b0);
        compare_exc("out_exc", out_exc, '0);
        compare_alu("out_alu", out_alu, ALU_ADD);
        checking = 1'b1;
        @(posedge d_clk);
        finish_test("reset");

        repeat (300) begin
            send_word(legal_word(), 0, 0);
            maybe_gap();
        end
        finish_test("legal");

        // back to back words so that a word waits out an illegal self stall
        repeat (100)
            send_word(any_word(), 0, 0);
        finish_test("random");

        foreach (sys_words[i]) begin
            send_word(sys_words[i], 0, 0);
            maybe_gap();
        end
        finish_test("system");

        repeat (100)
            send_word(legal_word(), 40, 0);
        finish_test("stall");

        repeat (100)
            send_word(any_word(), 0, 30);
        finish_test("flush");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verification
logic/rv_decode_pkg.sv
logic/decode_bus_if.sv
logic/field_decoder.sv
logic/instr_checker.sv
logic/decode_stage_reg.sv
logic/decode_top.sv
verification/decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module decode_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vdecode_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1
